//--- Makefile
# tools and options, each can be overridden on the command line
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_sa_ctrl
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= TESTS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- sources.f
+incdir+verilog
verilog/sa_ctrl_pkg.sv
verilog/seq_cmd_if.sv
verilog/inst_decoder.sv
verilog/read_sequencer.sv
verilog/weight_load_enable.sv
verilog/pe_enable_chain.sv
verilog/sa_ctrl_top.sv
testbench/tb_sa_ctrl.sv

//--- testbench/tb_sa_ctrl.sv
`include "sa_ctrl_consts.svh"

module tb_sa_ctrl;
    import sa_ctrl_pkg::*;

    // cfg holds {mode, bit mode, sign}
    typedef struct packed {
        inst_t      inst;
        logic [2:0] cfg;
        sa_num_t    num;
        logic       pulse;
        logic       drain;
    } row_t;

    logic       clk = 1'b0;
    logic       rstn;
    inst_t      inst;
    logic       inst_valid;
    logic       inst_ready, mode, bit_mode, is_sign, sram_r_cen, sram_set_w, valid_in;
    sa_num_t    sa_num;
    sram_addr_t sram_r_addr, sram_w_base;
    sa_mask_t   sa_pe_en;
    sa_mask_t [`SA_KH_ROWS-1:0] load_lines;

    // reference model, one entry per clock cycle
    bit         rd_q [8192];
    bit         ld_q [8192];
    bit         busy_q [8192];
    bit         pulse_q [8192];
    sram_addr_t addr_q [8192];
    sa_idx_t    sa_q [8192];
    logic       m_mode = 1'b0, m_bmode = 1'b0, m_sign = 1'b0;
    sa_num_t    m_num = 3'd1;
    sram_addr_t m_wbase = '0, m_ibase = '0, m_obase = '0;

    row_t  rows [$];
    string names [$];
    int    cyc = 16;
    int    last_end, errors, checks, tests, failed;
    bit    accepted;

    sa_ctrl_top u_dut (
        .clk                    (clk),
        .rstn                   (rstn),
        .inst_i                 (inst),
        .inst_valid_i           (inst_valid),
        .inst_ready_o           (inst_ready),
        .mode_o                 (mode),
        .bit_mode_o             (bit_mode),
        .is_sign_o              (is_sign),
        .sa_num_o               (sa_num),
        .sram_r_addr_o          (sram_r_addr),
        .sram_r_cen_o           (sram_r_cen),
        .sram_w_base_addr_o     (sram_w_base),
        .sram_set_w_base_addr_o (sram_set_w),
        .valid_in_o             (valid_in),
        .sa_pe_en_o             (sa_pe_en),
        .load_weight_en_line_o  (load_lines)
    );

    always #10 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    task automatic check_val(string sig, logic [31:0] got, logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error t=%0t %s got %0h expected %0h", $time, sig, got, exp);
        end
    endtask

    function automatic inst_t enc_setup(bit md, bit bm, logic [3:0] num, bit sg);
        return {`SA_OPC_SETUP, md, 3'b000, bm, num, sg, 3'b000};
    endfunction

    function automatic inst_t enc_addr(logic [2:0] opc, sram_addr_t a);
        return {opc, 3'b000, a};
    endfunction

    // update the model for an instruction accepted at edge cyc
    task automatic model_accept(inst_t ins);
        int         n;
        sram_addr_t base;
        accepted = 1'b1;
        case (ins[15:13])
            `SA_OPC_SETUP: begin
                m_mode  = ins[12];
                m_bmode = ins[8];
                m_sign  = ins[3];
                if (ins[7:4] == 4'd0)
                    m_num = 3'd1;
                else if (ins[7:4] > 4'd`SA_NUM)
                    m_num = 3'd`SA_NUM;
                else
                    m_num = sa_num_t'(ins[7:4]);
            end
            `SA_OPC_SET_WBASE: m_wbase = ins[9:0];
            `SA_OPC_SET_IBASE: m_ibase = ins[9:0];
            `SA_OPC_SET_OBASE: begin
                m_obase      = ins[9:0];
                pulse_q[cyc] = 1'b1;
            end
            `SA_OPC_LOAD, `SA_OPC_COMPUTE: begin
                n    = `SA_KH_ROWS * m_num;
                base = (ins[15:13] == `SA_OPC_LOAD) ? m_wbase : m_ibase;
                for (int i = 0; i < n; i++) begin
                    rd_q[cyc+1+i]   = 1'b1;
                    ld_q[cyc+1+i]   = (ins[15:13] == `SA_OPC_LOAD);
                    sa_q[cyc+1+i]   = sa_idx_t'(i / `SA_KH_ROWS);
                    addr_q[cyc+1+i] = sram_addr_t'(base + i);
                end
                for (int i = 0; i <= n; i++)
                    busy_q[cyc+i] = 1'b1;
                if (ins[15:13] == `SA_OPC_LOAD)
                    m_wbase = sram_addr_t'(base + n);
                else
                    m_ibase = sram_addr_t'(base + n);
                last_end = cyc + n + 1;
            end
            default: ;
        endcase
    endtask

    task automatic check_cycle();
        int c;
        int k;
        int j;
        c = cyc;
        check_val("inst_ready_o", 32'(inst_ready), 32'(!busy_q[c]));
        check_val("sram_r_cen_o", 32'(sram_r_cen), 32'(!rd_q[c]));
        if (rd_q[c])
            check_val("sram_r_addr_o", 32'(sram_r_addr), 32'(addr_q[c]));
        check_val("valid_in_o", 32'(valid_in), 32'(rd_q[c-1] && !ld_q[c-1]));
        // array k follows array 0 by SA_KH_ROWS cycles each
        for (k = 0; k < `SA_NUM; k++)
            check_val($sformatf("sa_pe_en_o[%0d]", k), 32'(sa_pe_en[k]),
                      32'(rd_q[c-1-`SA_KH_ROWS*k]));
        for (j = 0; j < `SA_KH_ROWS; j++)
            check_val($sformatf("load_weight_en_line_o[%0d]", j), 32'(load_lines[j]),
                      (rd_q[c-1-j] && ld_q[c-1-j]) ? (32'(1) << sa_q[c-1-j]) : 32'(0));
        check_val("mode_o", 32'(mode), 32'(m_mode));
        check_val("bit_mode_o", 32'(bit_mode), 32'(m_bmode));
        check_val("is_sign_o", 32'(is_sign), 32'(m_sign));
        check_val("sa_num_o", 32'(sa_num), 32'(m_num));
        check_val("sram_set_w_base_addr_o", 32'(sram_set_w), 32'(pulse_q[c]));
        check_val("sram_w_base_addr_o", 32'(sram_w_base), 32'(m_obase));
    endtask

    // the edge just passed accepts the instruction if the model was ready
    task automatic tick();
        @(negedge clk);
        if (inst_valid && !busy_q[cyc-1])
            model_accept(inst);
        if (rstn)
            check_cycle();
    endtask

    task automatic wait_idle();
        int t;
        t = 0;
        while (!inst_ready && t < 200) begin
            tick();
            t++;
        end
        if (!inst_ready) begin
            errors++;
            $display("ready did not return within 200 cycles after a run");
        end else begin
            check_val("inst_ready_o return cycle", 32'(cyc), 32'(last_end));
        end
        // let the pe chain and load lines drain
        repeat (16) tick();
    endtask

    task automatic apply_row(int idx);
        int t;
        inst       = rows[idx].inst;
        inst_valid = 1'b1;
        accepted   = 1'b0;
        t          = 0;
        while (!accepted && t < 100) begin
            tick();
            t++;
        end
        inst_valid = 1'b0;
        if (!accepted) begin
            errors++;
            $display("instruction of %s was not accepted within 100 cycles", names[idx]);
        end
        check_val("mode_o", 32'(mode), 32'(rows[idx].cfg[2]));
        check_val("bit_mode_o", 32'(bit_mode), 32'(rows[idx].cfg[1]));
        check_val("is_sign_o", 32'(is_sign), 32'(rows[idx].cfg[0]));
        check_val("sa_num_o", 32'(sa_num), 32'(rows[idx].num));
        check_val("sram_set_w_base_addr_o", 32'(sram_set_w), 32'(rows[idx].pulse));
        if (rows[idx].drain)
            wait_idle();
    endtask

    task automatic add_row(string name, inst_t ins, logic [2:0] cfg, sa_num_t num,
                           bit pulse, bit drain);
        rows.push_back('{ins, cfg, num, pulse, drain});
        names.push_back(name);
    endtask

    task automatic build_table();
        sram_addr_t wb;
        sram_addr_t ib;
        sram_addr_t ob;
        wb = sram_addr_t'($urandom);
        ib = sram_addr_t'($urandom);
        ob = sram_addr_t'($urandom);
        add_row("setup one array", enc_setup(1'b1, 1'b1, 4'd1, 1'b0), 3'b110, 3'd1, 1'b0, 1'b0);
        add_row("set weight base", enc_addr(`SA_OPC_SET_WBASE, wb), 3'b110, 3'd1, 1'b0, 1'b0);
        add_row("load one array", enc_addr(`SA_OPC_LOAD, '0), 3'b110, 3'd1, 1'b0, 1'b1);
        add_row("setup two arrays", enc_setup(1'b0, 1'b1, 4'd2, 1'b1), 3'b011, 3'd2, 1'b0, 1'b0);
        add_row("load two arrays", enc_addr(`SA_OPC_LOAD, '0), 3'b011, 3'd2, 1'b0, 1'b1);
        add_row("setup three arrays", enc_setup(1'b1, 1'b0, 4'd3, 1'b0), 3'b100, 3'd3, 1'b0, 1'b0);
        add_row("load three arrays", enc_addr(`SA_OPC_LOAD, '0), 3'b100, 3'd3, 1'b0, 1'b1);
        add_row("setup zero arrays", enc_setup(1'b0, 1'b0, 4'd0, 1'b1), 3'b001, 3'd1, 1'b0, 1'b0);
        add_row("setup nine arrays", enc_setup(1'b1, 1'b0, 4'd9, 1'b1), 3'b101, 3'd4, 1'b0, 1'b0);
        add_row("load four arrays", enc_addr(`SA_OPC_LOAD, '0), 3'b101, 3'd4, 1'b0, 1'b1);
        add_row("set input base", enc_addr(`SA_OPC_SET_IBASE, ib), 3'b101, 3'd4, 1'b0, 1'b0);
        add_row("compute first", enc_addr(`SA_OPC_COMPUTE, '0), 3'b101, 3'd4, 1'b0, 1'b0);
        add_row("compute second", enc_addr(`SA_OPC_COMPUTE, '0), 3'b101, 3'd4, 1'b0, 1'b1);
        add_row("set output base", enc_addr(`SA_OPC_SET_OBASE, ob), 3'b101, 3'd4, 1'b1, 1'b0);
        add_row("nop", enc_addr(`SA_OPC_NOP, '0), 3'b101, 3'd4, 1'b0, 1'b0);
    endtask

    task automatic report_test(string name, int e0);
        tests++;
        if (errors != e0)
            failed++;
        $display("test %0d %s: %s", tests, name, (errors == e0) ? "ok" : "failed");
    endtask

    initial begin
        int e0;
        void'($urandom(32'h5c22));
        rstn       = 1'b0;
        inst       = '0;
        inst_valid = 1'b0;
        build_table();
        repeat (4) @(negedge clk);
        rstn = 1'b1;
        e0   = errors;
        repeat (3) tick();
        report_test("reset", e0);
        for (int i = 0; i < rows.size(); i++) begin
            e0 = errors;
            apply_row(i);
            repeat (2) tick();
            report_test(names[i], e0);
        end
        $display("%0d tests, %0d failed, %0d checks, %0d errors", tests, failed, checks, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- verilog/inst_decoder.sv
`include "sa_ctrl_consts.svh"

module inst_decoder (
    input  logic                    clk,
    input  logic                    rstn,
    input  sa_ctrl_pkg::inst_t      inst_i,
    input  logic                    inst_valid_i,
    output logic                    inst_ready_o,
    output logic                    mode_o,
    output logic                    bit_mode_o,
    output logic                    is_sign_o,
    output sa_ctrl_pkg::sa_num_t    sa_num_o,
    output sa_ctrl_pkg::sram_addr_t sram_w_base_addr_o,
    output logic                    sram_set_w_base_addr_o,
    seq_cmd_if.decoder              cmd
);
    import sa_ctrl_pkg::*;

    opcode_e    opcode;
    logic       accept;
    logic [3:0] num_field;
    logic       run_start;
    run_op_e    run_op;
    sram_addr_t w_base;
    sram_addr_t i_base;

    assign accept    = inst_valid_i && inst_ready_o;
    assign opcode    = opcode_e'(inst_i[`SA_INST_W-1 -: 3]);
    assign num_field = inst_i[7:4];

    // setup fields, array count clipped to 1..SA_NUM
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mode_o     <= 1'b0;
            bit_mode_o <= 1'b0;
            is_sign_o  <= 1'b0;
            sa_num_o   <= sa_num_t'(1);
        end else if (accept && opcode == OPC_SETUP) begin
            mode_o     <= inst_i[12];
            bit_mode_o <= inst_i[8];
            is_sign_o  <= inst_i[3];
            if (num_field == 4'd0)
                sa_num_o <= sa_num_t'(1);
            else if (num_field > 4'(`SA_NUM))
                sa_num_o <= sa_num_t'(`SA_NUM);
            else
                sa_num_o <= sa_num_t'(num_field);
        end
    end

    // base registers, a finished run moves its base past the words read
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            w_base                 <= '0;
            i_base                 <= '0;
            sram_w_base_addr_o     <= '0;
            sram_set_w_base_addr_o <= 1'b0;
        end else begin
            sram_set_w_base_addr_o <= accept && opcode == OPC_SET_OBASE;
            if (accept && opcode == OPC_SET_WBASE)
                w_base <= inst_i[`SA_ADDR_W-1:0];
            if (accept && opcode == OPC_SET_IBASE)
                i_base <= inst_i[`SA_ADDR_W-1:0];
            if (accept && opcode == OPC_SET_OBASE)
                sram_w_base_addr_o <= inst_i[`SA_ADDR_W-1:0];
            if (cmd.done && run_op == RUN_LOAD)
                w_base <= cmd.next_addr;
            if (cmd.done && run_op == RUN_COMPUTE)
                i_base <= cmd.next_addr;
        end
    end

    // run launch, ready stays low until the sequencer is done
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            inst_ready_o <= 1'b1;
            run_start    <= 1'b0;
            run_op       <= RUN_LOAD;
        end else begin
            run_start <= 1'b0;
            if (accept && (opcode == OPC_LOAD || opcode == OPC_COMPUTE)) begin
                inst_ready_o <= 1'b0;
                run_start    <= 1'b1;
                run_op       <= (opcode == OPC_LOAD) ? RUN_LOAD : RUN_COMPUTE;
            end else if (cmd.done) begin
                inst_ready_o <= 1'b1;
            end
        end
    end

    assign cmd.start  = run_start;
    assign cmd.op     = run_op;
    assign cmd.sa_num = sa_num_o;
    assign cmd.base   = (run_op == RUN_LOAD) ? w_base : i_base;

endmodule

//--- verilog/pe_enable_chain.sv
`include "sa_ctrl_consts.svh"

module pe_enable_chain (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  rd_fire_i,
    output sa_ctrl_pkg::sa_mask_t sa_pe_en_o
);

    logic                                  pe_en0;
    logic [(`SA_NUM-1)*`SA_KH_ROWS-1:0]    pe_dly;

    // array 0 runs with the data coming back from sram
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pe_en0 <= 1'b0;
            pe_dly <= '0;
        end else begin
            pe_en0 <= rd_fire_i;
            pe_dly <= {pe_dly[(`SA_NUM-1)*`SA_KH_ROWS-2:0], pe_en0};
        end
    end

    assign sa_pe_en_o[0] = pe_en0;

    // tap every SA_KH_ROWS stages, one array further each time
    for (genvar k = 1; k < `SA_NUM; k++) begin : g_tap
        assign sa_pe_en_o[k] = pe_dly[k*`SA_KH_ROWS-1];
    end

endmodule

//--- verilog/read_sequencer.sv
`include "sa_ctrl_consts.svh"

module read_sequencer (
    input  logic                    clk,
    input  logic                    rstn,
    seq_cmd_if.sequencer            cmd,
    output sa_ctrl_pkg::sram_addr_t sram_r_addr_o,
    output logic                    sram_r_cen_o,
    output logic                    valid_in_o,
    output logic                    rd_fire_o,
    output logic                    rd_load_o,
    output sa_ctrl_pkg::sa_idx_t    rd_sa_o
);
    import sa_ctrl_pkg::*;

    seq_state_e state;
    kh_cnt_t    kh_cnt;
    sa_idx_t    sa_cnt;
    sa_num_t    run_num;
    run_op_e    run_op;
    sram_addr_t rd_addr;
    logic       kh_last;
    logic       last_rd;

    assign kh_last = (kh_cnt == kh_cnt_t'(`SA_KH_ROWS - 1));
    // last row of the last array in this run
    assign last_rd = (state == SEQ_READ) && kh_last
                   && (sa_num_t'(sa_cnt) == run_num - sa_num_t'(1));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state   <= SEQ_IDLE;
            kh_cnt  <= '0;
            sa_cnt  <= '0;
            run_num <= sa_num_t'(1);
            run_op  <= RUN_LOAD;
            rd_addr <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (cmd.start) begin
                        state   <= SEQ_READ;
                        kh_cnt  <= '0;
                        sa_cnt  <= '0;
                        run_num <= cmd.sa_num;
                        run_op  <= cmd.op;
                        rd_addr <= cmd.base;
                    end
                end
                SEQ_READ: begin
                    // one word per cycle, kh wraps into the next array
                    rd_addr <= rd_addr + 1'b1;
                    kh_cnt  <= kh_cnt + 1'b1;
                    if (kh_last)
                        sa_cnt <= sa_cnt + 1'b1;
                    if (last_rd)
                        state <= SEQ_IDLE;
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // shifter sees data one cycle after the read
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            valid_in_o <= 1'b0;
        else
            valid_in_o <= rd_fire_o && run_op == RUN_COMPUTE;
    end

    assign sram_r_addr_o = rd_addr;
    assign sram_r_cen_o  = (state != SEQ_READ);
    assign rd_fire_o     = (state == SEQ_READ);
    assign rd_load_o     = (run_op == RUN_LOAD);
    assign rd_sa_o       = sa_cnt;

    assign cmd.done      = last_rd;
    assign cmd.next_addr = rd_addr + 1'b1;

endmodule

//--- verilog/sa_ctrl_consts.svh
`ifndef SA_CTRL_CONSTS_SVH
`define SA_CTRL_CONSTS_SVH

// widths
`define SA_INST_W   16
`define SA_ADDR_W   10

// array geometry, rows per array is also the pe delay between arrays
`define SA_NUM      4
`define SA_KH_ROWS  4

// opcodes in the top three instruction bits
`define SA_OPC_NOP        3'd0
`define SA_OPC_SETUP      3'd1
`define SA_OPC_LOAD       3'd2
`define SA_OPC_COMPUTE    3'd3
`define SA_OPC_SET_WBASE  3'd4
`define SA_OPC_SET_IBASE  3'd5
`define SA_OPC_SET_OBASE  3'd6

`endif

//--- verilog/sa_ctrl_pkg.sv
`include "sa_ctrl_consts.svh"

package sa_ctrl_pkg;

    typedef logic [`SA_INST_W-1:0]             inst_t;
    typedef logic [`SA_ADDR_W-1:0]             sram_addr_t;
    // array count 1..SA_NUM needs one extra bit
    typedef logic [$clog2(`SA_NUM):0]          sa_num_t;
    typedef logic [$clog2(`SA_NUM)-1:0]        sa_idx_t;
    typedef logic [$clog2(`SA_KH_ROWS)-1:0]    kh_cnt_t;
    typedef logic [`SA_NUM-1:0]                sa_mask_t;

    typedef enum logic [2:0] {
        OPC_NOP       = `SA_OPC_NOP,
        OPC_SETUP     = `SA_OPC_SETUP,
        OPC_LOAD      = `SA_OPC_LOAD,
        OPC_COMPUTE   = `SA_OPC_COMPUTE,
        OPC_SET_WBASE = `SA_OPC_SET_WBASE,
        OPC_SET_IBASE = `SA_OPC_SET_IBASE,
        OPC_SET_OBASE = `SA_OPC_SET_OBASE
    } opcode_e;

    typedef enum logic {RUN_LOAD, RUN_COMPUTE} run_op_e;

    typedef enum logic {SEQ_IDLE, SEQ_READ} seq_state_e;

endpackage

//--- verilog/sa_ctrl_top.sv
`include "sa_ctrl_consts.svh"

module sa_ctrl_top (
    input  logic                                     clk,
    input  logic                                     rstn,
    input  sa_ctrl_pkg::inst_t                       inst_i,
    input  logic                                     inst_valid_i,
    output logic                                     inst_ready_o,
    output logic                                     mode_o,
    output logic                                     bit_mode_o,
    output logic                                     is_sign_o,
    output sa_ctrl_pkg::sa_num_t                     sa_num_o,
    output sa_ctrl_pkg::sram_addr_t                  sram_r_addr_o,
    output logic                                     sram_r_cen_o,
    output sa_ctrl_pkg::sram_addr_t                  sram_w_base_addr_o,
    output logic                                     sram_set_w_base_addr_o,
    output logic                                     valid_in_o,
    output sa_ctrl_pkg::sa_mask_t                    sa_pe_en_o,
    output sa_ctrl_pkg::sa_mask_t [`SA_KH_ROWS-1:0]  load_weight_en_line_o
);
    import sa_ctrl_pkg::*;

    logic    rd_fire;
    logic    rd_load;
    sa_idx_t rd_sa;

    seq_cmd_if u_cmd ();

    inst_decoder u_decoder (
        .clk                    (clk),
        .rstn                   (rstn),
        .inst_i                 (inst_i),
        .inst_valid_i           (inst_valid_i),
        .inst_ready_o           (inst_ready_o),
        .mode_o                 (mode_o),
        .bit_mode_o             (bit_mode_o),
        .is_sign_o              (is_sign_o),
        .sa_num_o               (sa_num_o),
        .sram_w_base_addr_o     (sram_w_base_addr_o),
        .sram_set_w_base_addr_o (sram_set_w_base_addr_o),
        .cmd                    (u_cmd.decoder)
    );

    read_sequencer u_sequencer (
        .clk           (clk),
        .rstn          (rstn),
        .cmd           (u_cmd.sequencer),
        .sram_r_addr_o (sram_r_addr_o),
        .sram_r_cen_o  (sram_r_cen_o),
        .valid_in_o    (valid_in_o),
        .rd_fire_o     (rd_fire),
        .rd_load_o     (rd_load),
        .rd_sa_o       (rd_sa)
    );

    weight_load_enable u_wload (
        .clk                   (clk),
        .rstn                  (rstn),
        .rd_load_i             (rd_load),
        .rd_fire_i             (rd_fire),
        .rd_sa_i               (rd_sa),
        .load_weight_en_line_o (load_weight_en_line_o)
    );

    pe_enable_chain u_pe_chain (
        .clk        (clk),
        .rstn       (rstn),
        .rd_fire_i  (rd_fire),
        .sa_pe_en_o (sa_pe_en_o)
    );

endmodule

//--- verilog/seq_cmd_if.sv
interface seq_cmd_if;
    import sa_ctrl_pkg::*;

    // run request, valid while start is high
    logic       start;
    run_op_e    op;
    sa_num_t    sa_num;
    sram_addr_t base;

    // finish report, next_addr is one past the last read
    logic       done;
    sram_addr_t next_addr;

    modport decoder (
        output start, op, sa_num, base,
        input  done, next_addr
    );

    modport sequencer (
        input  start, op, sa_num, base,
        output done, next_addr
    );

endinterface

//--- verilog/weight_load_enable.sv
`include "sa_ctrl_consts.svh"

module weight_load_enable (
    input  logic                                     clk,
    input  logic                                     rstn,
    input  logic                                     rd_load_i,
    input  logic                                     rd_fire_i,
    input  sa_ctrl_pkg::sa_idx_t                     rd_sa_i,
    output sa_ctrl_pkg::sa_mask_t [`SA_KH_ROWS-1:0]  load_weight_en_line_o
);
    import sa_ctrl_pkg::*;

    // stage j feeds row j of the arrays
    logic [`SA_KH_ROWS-1:0] ld_en_q;
    sa_idx_t                ld_sa_q [`SA_KH_ROWS];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            ld_en_q <= '0;
        else
            ld_en_q <= {ld_en_q[`SA_KH_ROWS-2:0], rd_fire_i && rd_load_i};
    end

    // array index moves down the line beside its enable
    always_ff @(posedge clk) begin
        ld_sa_q[0] <= rd_sa_i;
        for (int j = 1; j < `SA_KH_ROWS; j++) begin
            ld_sa_q[j] <= ld_sa_q[j-1];
        end
    end

    always_comb begin
        for (int j = 0; j < `SA_KH_ROWS; j++) begin
            if (ld_en_q[j])
                load_weight_en_line_o[j] = sa_mask_t'(1) << ld_sa_q[j];
            else
                load_weight_en_line_o[j] = '0;
        end
    end

endmodule
